// ==== fetch_pkg.sv ====
/* buffer-side constants, fetch word union and the consume command
   shared by the fetch queue and the instruction aligner */
`default_nettype none

package fetch_pkg;

  // number of word slots held between bus and aligner
  localparam int QUEUE_DEPTH = 3;

  // instruction and address width
  localparam int XLEN = 32;

  // a fetched word split into its two halfwords
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } halfwords_t;

  // queue stores the full word, aligner picks halves for straddled instructions
  typedef union packed {
    logic [XLEN-1:0] word;
    halfwords_t      half;
  } fetch_word_u;

  // aligner command to the queue, applied on an output transfer
  typedef struct packed {
    // drop the head slot
    logic pop;
    // halfword offset of the new head instruction
    logic half;
  } consume_t;

endpackage

`default_nettype wire

// ==== ibus_pkg.sv ====
/* instruction bus request and response structs, address helper constants */
`default_nettype none

package ibus_pkg;

  // bus address and data widths
  localparam int IBUS_AW = 32;
  localparam int IBUS_DW = 32;

  // byte offset bits below a bus word
  localparam int WORD_OFFSET_BITS = 2;

  // core to memory, address held stable until grant
  typedef struct packed {
    logic               req;
    logic [IBUS_AW-1:0] addr;
  } ibus_req_t;

  // memory to core
  typedef struct packed {
    // request accepted this cycle
    logic               gnt;
    // read word returned this cycle, one per grant
    logic               rvalid;
    logic [IBUS_DW-1:0] rdata;
  } ibus_rsp_t;

endpackage

`default_nettype wire

// ==== fetch_fsm.sv ====
/* instruction bus FSM with fetch address register, slot reservation
   and discard of responses aborted by a branch */
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm
  import fetch_pkg::*;
  import ibus_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_i,
  input  logic            branch_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            space_i,
  input  ibus_rsp_t       ibus_rsp_i,
  output ibus_req_t       ibus_req_o,
  output logic            reserve_o,
  output logic            fill_o,
  output fetch_word_u     fill_data_o,
  output logic            idle_o
);

  typedef enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RVALID, WAIT_ABORTED} state_e;

  state_e          state_q, state_d;
  logic [XLEN-1:0] fetch_addr_q, fetch_addr_d;
  logic [XLEN-1:0] branch_word;
  logic [XLEN-1:0] req_addr;
  logic            bus_req;
  logic            start;

  // word aligned branch target
  assign branch_word = {branch_addr_i[XLEN-1:WORD_OFFSET_BITS], {WORD_OFFSET_BITS{1'b0}}};

  // a branch always wants a word, otherwise only with a free slot
  assign start = branch_i || (req_i && space_i);

  // branch target goes out combinationally in the branch cycle
  assign req_addr   = branch_i ? branch_word : fetch_addr_q;
  assign ibus_req_o = '{req: bus_req, addr: req_addr};

  assign fill_data_o.word = ibus_rsp_i.rdata;
  // slot is claimed when the bus accepts the request
  assign reserve_o        = bus_req && ibus_rsp_i.gnt;
  assign idle_o           = (state_q == IDLE);

  // next word after each grant, branch target otherwise
  assign fetch_addr_d = reserve_o ?
    {req_addr[XLEN-1:WORD_OFFSET_BITS] + 1'b1, {WORD_OFFSET_BITS{1'b0}}} : req_addr;

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    bus_req = 1'b0;
    fill_o  = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (start) begin
          bus_req = 1'b1;
          state_d = ibus_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        // keep asking, a branch only swaps the address
        bus_req = 1'b1;
        if (ibus_rsp_i.gnt) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (ibus_rsp_i.rvalid) begin
          // word of a flushed stream is not stored
          fill_o = !branch_i;
          // only one outstanding, so the next request goes with the response
          if (start) begin
            bus_req = 1'b1;
            state_d = ibus_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          state_d = WAIT_ABORTED;
        end
      end
      WAIT_ABORTED: begin
        // late response dropped, then fetch from the stored target
        if (ibus_rsp_i.rvalid) begin
          bus_req = 1'b1;
          state_d = ibus_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      fetch_addr_q <= '0;
    end else begin
      state_q      <= state_d;
      fetch_addr_q <= fetch_addr_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // an ungranted request stays up with the same address unless redirected
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ibus_req_o.req && !ibus_rsp_i.gnt) |=>
      (ibus_req_o.req && (branch_i || $stable(ibus_req_o.addr))))
    else $error("request dropped or address changed before grant");

  // memory answers only while a response is outstanding
  a_rvalid_expected: assert property (@(posedge clk) disable iff (!rst_n)
    ibus_rsp_i.rvalid |-> (state_q inside {WAIT_RVALID, WAIT_ABORTED}))
    else $error("rvalid without outstanding request");

endmodule

`default_nettype wire

// ==== fetch_queue.sv ====
/* word queue with slot reservation, in-order fill, output address
   tracking and flush on branch */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
  import fetch_pkg::*;
  import ibus_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            branch_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            reserve_i,
  input  logic            fill_i,
  input  fetch_word_u     fill_data_i,
  input  consume_t        consume_i,
  input  logic            transfer_i,
  output logic            space_o,
  output fetch_word_u     head_o,
  output fetch_word_u     next_o,
  output logic            head_full_o,
  output logic            next_full_o,
  output logic            head_half_o,
  output logic [XLEN-1:0] out_addr_o
);

  // slot 0 is the head, reserved slots are always packed from slot 0
  logic [QUEUE_DEPTH-1:0] rsv_q, rsv_d;
  logic [QUEUE_DEPTH-1:0] full_q, full_d;
  fetch_word_u            data_q [QUEUE_DEPTH];
  fetch_word_u            data_d [QUEUE_DEPTH];
  logic [XLEN-1:0]        out_addr_q;
  logic                   pop;

  assign pop = transfer_i && consume_i.pop;

  ////////////////////////////////////////////////////////////////////////////
  // slot update: fill, then pop, then flush, then reserve
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    logic filled;
    logic placed;
    filled = 1'b0;
    placed = 1'b0;
    rsv_d  = rsv_q;
    full_d = full_q;
    data_d = data_q;
    // response lands in the oldest slot still waiting
    if (fill_i) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        if (rsv_q[i] && !full_q[i] && !filled) begin
          full_d[i] = 1'b1;
          data_d[i] = fill_data_i;
          filled    = 1'b1;
        end
      end
    end
    // shift everything one slot towards the head
    if (pop) begin
      for (int i = 0; i < QUEUE_DEPTH-1; i++) begin
        rsv_d[i]  = rsv_d[i+1];
        full_d[i] = full_d[i+1];
        data_d[i] = data_d[i+1];
      end
      rsv_d[QUEUE_DEPTH-1]  = 1'b0;
      full_d[QUEUE_DEPTH-1] = 1'b0;
    end
    // branch wins over any fill or transfer in the same cycle
    if (branch_i) begin
      rsv_d  = '0;
      full_d = '0;
    end
    // a grant in the branch cycle already belongs to the new stream
    if (reserve_i) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        if (!rsv_d[i] && !placed) begin
          rsv_d[i] = 1'b1;
          placed   = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsv_q      <= '0;
      full_q     <= '0;
      out_addr_q <= '0;
    end else begin
      rsv_q  <= rsv_d;
      full_q <= full_d;
      if (branch_i) begin
        out_addr_q <= branch_addr_i;
      end else if (transfer_i) begin
        // word part steps on pop, halfword bit comes from the aligner
        // so the address moves by 2 or 4 bytes
        out_addr_q <= {out_addr_q[XLEN-1:WORD_OFFSET_BITS] + pop, consume_i.half, 1'b0};
      end
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    data_q <= data_d;
  end

  // free slot left for one more request
  assign space_o     = !rsv_q[QUEUE_DEPTH-1];
  assign head_o      = data_q[0];
  assign next_o      = data_q[1];
  assign head_full_o = full_q[0];
  assign next_full_o = full_q[1];
  // head offset follows the halfword bit of the output address
  assign head_half_o = out_addr_q[1];
  assign out_addr_o  = out_addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // every response has a slot waiting for it
  a_fill_has_slot: assert property (@(posedge clk) disable iff (!rst_n)
    fill_i |-> |(rsv_q & ~full_q))
    else $error("fill without reserved empty slot");

  // FSM only claims a slot that is free, a flush frees all of them
  a_reserve_space: assert property (@(posedge clk) disable iff (!rst_n)
    (reserve_i && !branch_i) |-> space_o)
    else $error("reservation into full queue");

endmodule

`default_nettype wire

// ==== instr_aligner.sv ====
/* instruction aligner for mixed 16 and 32 bit instructions */
`timescale 1ns/1ps
`default_nettype none

module instr_aligner
  import fetch_pkg::*;
(
  input  fetch_word_u     head_i,
  input  fetch_word_u     next_i,
  input  logic            head_full_i,
  input  logic            next_full_i,
  input  logic            head_half_i,
  output logic            valid_o,
  output logic [XLEN-1:0] rdata_o,
  output consume_t        consume_o
);

  logic [15:0] first_half;
  logic        compressed;

  // halfword where the current instruction starts
  assign first_half = head_half_i ? head_i.half.hi : head_i.half.lo;
  // low bits not both set mark a 16 bit instruction
  assign compressed = (first_half[1:0] != 2'b11);

  always_comb begin
    if (!head_half_i) begin
      // aligned start takes the whole head word
      rdata_o = head_i.word;
      valid_o = head_full_i;
      if (compressed) begin
        // stay on this word and move to the upper half
        consume_o = '{pop: 1'b0, half: 1'b1};
      end else begin
        consume_o = '{pop: 1'b1, half: 1'b0};
      end
    end else begin
      // upper half of head joined with lower half of the next slot
      rdata_o = {next_i.half.lo, head_i.half.hi};
      if (compressed) begin
        valid_o   = head_full_i;
        consume_o = '{pop: 1'b1, half: 1'b0};
      end else begin
        // straddling instruction needs both words present
        valid_o   = head_full_i && next_full_i;
        consume_o = '{pop: 1'b1, half: 1'b1};
      end
    end
  end

endmodule

`default_nettype wire

// ==== prefetch_buffer.sv ====
/* prefetch buffer top level: fetch FSM, word queue and aligner */
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer
  import fetch_pkg::*;
  import ibus_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_i,
  input  logic            branch_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            ready_i,
  input  ibus_rsp_t       ibus_rsp_i,
  output logic            valid_o,
  output logic [XLEN-1:0] rdata_o,
  output logic [XLEN-1:0] addr_o,
  output ibus_req_t       ibus_req_o,
  output logic            busy_o
);

  logic        space;
  logic        reserve;
  logic        fill;
  fetch_word_u fill_data;
  logic        fsm_idle;
  fetch_word_u head, next;
  logic        head_full, next_full;
  logic        head_half;
  consume_t    consume;
  logic        transfer;

  // output handshake, discarded by the queue in a branch cycle
  assign transfer = valid_o && ready_i;
  // busy while a request or response is in flight
  assign busy_o   = !fsm_idle || ibus_req_o.req;

  // bus side, fills the queue
  fetch_fsm u_fetch_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .space_i       (space),
    .ibus_rsp_i    (ibus_rsp_i),
    .ibus_req_o    (ibus_req_o),
    .reserve_o     (reserve),
    .fill_o        (fill),
    .fill_data_o   (fill_data),
    .idle_o        (fsm_idle)
  );

  fetch_queue u_fetch_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .reserve_i     (reserve),
    .fill_i        (fill),
    .fill_data_i   (fill_data),
    .consume_i     (consume),
    .transfer_i    (transfer),
    .space_o       (space),
    .head_o        (head),
    .next_o        (next),
    .head_full_o   (head_full),
    .next_full_o   (next_full),
    .head_half_o   (head_half),
    .out_addr_o    (addr_o)
  );

  // core side, drains the queue
  instr_aligner u_instr_aligner (
    .head_i        (head),
    .next_i        (next),
    .head_full_i   (head_full),
    .next_full_i   (next_full),
    .head_half_i   (head_half),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .consume_o     (consume)
  );

endmodule

`default_nettype wire

// ==== tb_mem.svh ====
/* instruction memory content for the testbench, a word per address
   with a mix of 16 and 32 bit instruction starts */

// maps a byte address to the word that holds it
function automatic logic [31:0] mem_word(input logic [31:0] addr);
  logic [29:0] w;
  logic [15:0] lo;
  logic [15:0] hi;
  w = addr[31:2];
  // payload from the whole word address
  lo[15:2] = w[13:0] ^ w[29:16];
  hi[15:2] = ~w[13:0] ^ {w[27:16], w[15:14]};
  // low half starts a full instruction on about half the words
  lo[1:0] = (w[0] ^ w[3]) ? 2'b11 : {w[1], 1'b0};
  // full instruction in the high half straddles into the next word
  hi[1:0] = (w[1] ^ w[2]) ? 2'b11 : {1'b0, w[0]};
  return {hi, lo};
endfunction

// ==== tb_checker.sv ====
/* output monitor for the prefetch buffer: reference model of the
   instruction stream, comparison and counts */
`timescale 1ns/1ps
`default_nettype none

module tb_checker
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            branch_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            valid_i,
  input  logic            ready_i,
  input  logic [XLEN-1:0] rdata_i,
  input  logic [XLEN-1:0] addr_i,
  output int              checks_o,
  output int              errors_o
);

  `include "tb_mem.svh"

  // one predicted instruction
  typedef struct packed {
    logic            compressed;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] next_addr;
  } expect_t;

  logic [XLEN-1:0] exp_addr;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic expect_t ref_instr(input logic [XLEN-1:0] addr);
    logic [31:0] word0;
    logic [31:0] word1;
    logic [15:0] first;
    logic [15:0] second;
    expect_t     e;
    word0 = mem_word(addr);
    word1 = mem_word(addr + 32'd4);
    // halfword at the address, then the one after it
    first  = addr[1] ? word0[31:16] : word0[15:0];
    second = addr[1] ? word1[15:0] : word0[31:16];
    e.compressed = (first[1:0] != 2'b11);
    if (e.compressed) begin
      e.instr     = {16'h0000, first};
      e.next_addr = addr + 32'd2;
    end else begin
      e.instr     = {second, first};
      e.next_addr = addr + 32'd4;
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // comparison
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin : compare
    expect_t want;
    logic    data_ok;
    if (!rst_n) begin
      exp_addr <= '0;
      checks_o <= 0;
      errors_o <= 0;
    end else if (branch_i) begin
      // new stream, a transfer in this cycle is dropped
      exp_addr <= branch_addr_i;
    end else if (valid_i && ready_i) begin
      want = ref_instr(exp_addr);
      // upper half of a 16 bit instruction is don't care
      if (want.compressed) begin
        data_ok = (rdata_i[15:0] == want.instr[15:0]);
      end else begin
        data_ok = (rdata_i == want.instr);
      end
      if (!data_ok || addr_i != exp_addr) begin
        $display("** Error at %0t: addr %h data %h, expected addr %h data %h",
                 $time, addr_i, rdata_i, exp_addr, want.instr);
        errors_o <= errors_o + 1;
      end
      checks_o <= checks_o + 1;
      exp_addr <= want.next_addr;
    end
  end

endmodule

`default_nettype wire

// ==== tb_prefetch.sv ====
/* testbench top for the prefetch buffer with clock, reset, bus responder
   of random latency and the test sequence */
`timescale 1ns/1ps
`default_nettype none

module tb_prefetch
  import fetch_pkg::*;
  import ibus_pkg::*;
();

  `include "tb_mem.svh"

  logic            clk;
  logic            rst_n;
  logic            req_i;
  logic            branch_i;
  logic [XLEN-1:0] branch_addr_i;
  logic            ready_i;
  ibus_rsp_t       ibus_rsp;
  ibus_req_t       ibus_req;
  logic            valid_o;
  logic [XLEN-1:0] rdata_o;
  logic [XLEN-1:0] addr_o;
  logic            busy_o;

  int          seed = 10845;
  int          checks;
  int          chk_errors;
  int          tb_errors = 0;
  int          tests_run = 0;
  int          mark_errs;
  int          mark_checks;
  logic        ready_random = 1'b0;
  logic [31:0] ready_rnd;
  logic [31:0] bus_rnd;
  logic        rsp_pending;
  logic [1:0]  rsp_delay;
  logic [31:0] rsp_addr;

  prefetch_buffer uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .ready_i       (ready_i),
    .ibus_rsp_i    (ibus_rsp),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .addr_o        (addr_o),
    .ibus_req_o    (ibus_req),
    .busy_o        (busy_o)
  );

  tb_checker chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .valid_i       (valid_o),
    .ready_i       (ready_i),
    .rdata_i       (rdata_o),
    .addr_i        (addr_o),
    .checks_o      (checks),
    .errors_o      (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus responder and output ready
  ////////////////////////////////////////////////////////////////////////////

  // grant only a waiting request and answer 1 to 4 cycles later
  initial begin
    ibus_rsp    = '0;
    rsp_pending = 1'b0;
    rsp_delay   = '0;
    rsp_addr    = '0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        ibus_rsp    <= '0;
        rsp_pending <= 1'b0;
      end else begin
        // an outstanding response keeps the buffer busy
        if (rsp_pending && !busy_o) begin
          $display("** Error at %0t: busy low with a response outstanding", $time);
          tb_errors++;
        end
        bus_rnd = $random(seed);
        ibus_rsp.rvalid <= 1'b0;
        if (rsp_pending) begin
          if (rsp_delay == 2'd0) begin
            ibus_rsp.rvalid <= 1'b1;
            ibus_rsp.rdata  <= mem_word(rsp_addr);
            rsp_pending     <= 1'b0;
          end else begin
            rsp_delay <= rsp_delay - 2'd1;
          end
        end
        if (ibus_req.req && ibus_rsp.gnt) begin
          // accepted request address kept for the response
          ibus_rsp.gnt <= 1'b0;
          rsp_pending  <= 1'b1;
          rsp_addr     <= ibus_req.addr;
          rsp_delay    <= bus_rnd[2:1];
        end else if (ibus_req.req && !rsp_pending) begin
          ibus_rsp.gnt <= bus_rnd[0];
        end
      end
    end
  end

  // ready held high or toggled at random
  initial begin
    ready_i = 1'b0;
    forever begin
      @(posedge clk);
      ready_rnd = $random(seed);
      ready_i <= ready_random ? ready_rnd[0] : 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers called on a rising edge
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] random_target();
    logic [31:0] a;
    a = $random(seed);
    return a & 32'h0000_3ffe;
  endfunction

  task automatic do_branch(input logic [31:0] addr);
    branch_i      <= 1'b1;
    branch_addr_i <= addr;
    req_i         <= 1'b1;
    @(posedge clk);
    branch_i <= 1'b0;
  endtask

  task automatic wait_transfers(input int count, input int limit);
    int target;
    int cycles;
    target = checks + count;
    cycles = 0;
    while (checks < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (checks < target) begin
      $display("timeout: %0d of %0d instructions arrived within %0d cycles",
               count - (target - checks), count, limit);
      tb_errors++;
    end
  endtask

  // returns on the edge that ends a grant cycle
  task automatic wait_grant(input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!(ibus_req.req && ibus_rsp.gnt) && cycles < limit);
    if (!(ibus_req.req && ibus_rsp.gnt)) begin
      $display("timeout: no bus grant within %0d cycles", limit);
      tb_errors++;
    end
  endtask

  task automatic open_test();
    mark_errs   = chk_errors + tb_errors;
    mark_checks = checks;
  endtask

  task automatic close_test(input int num, input string name);
    int errs;
    errs = chk_errors + tb_errors - mark_errs;
    tests_run++;
    $display("test %0d %s: %0d instructions, %0d errors, %s", num, name,
             checks - mark_checks, errs, (errs == 0) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    rst_n         = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // nothing moves before the first branch
    open_test();
    repeat (20) begin
      @(posedge clk);
      if (valid_o || ibus_req.req || busy_o) begin
        $display("** Error at %0t: valid %b req %b busy %b before first branch",
                 $time, valid_o, ibus_req.req, busy_o);
        tb_errors++;
      end
    end
    close_test(1, "reset idle");

    open_test();
    do_branch(32'h0000_0100);
    wait_transfers(40, 2000);
    close_test(2, "aligned stream");

    // start in the high half of a word
    open_test();
    do_branch(32'h0000_0346);
    wait_transfers(40, 2000);
    close_test(3, "halfword target");

    // odd rounds branch right after a grant while the response is in flight
    open_test();
    for (int i = 0; i < 12; i++) begin
      repeat ($unsigned($random(seed)) % 8) @(posedge clk);
      if (i % 2 == 1) begin
        wait_grant(200);
      end
      do_branch(random_target());
    end
    wait_transfers(30, 3000);
    close_test(4, "random branches");

    open_test();
    ready_random <= 1'b1;
    for (int k = 0; k < 3; k++) begin
      do_branch(random_target());
      wait_transfers(50, 5000);
    end
    ready_random <= 1'b0;
    close_test(5, "back-pressure");

    $display("summary: %0d tests, %0d instructions checked, %0d errors",
             tests_run, checks, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
fetch_pkg.sv
ibus_pkg.sv
fetch_fsm.sv
fetch_queue.sv
instr_aligner.sv
prefetch_buffer.sv
tb_checker.sv
tb_prefetch.sv

// ==== run.sh ====
#!/bin/sh
# build the prefetch buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_prefetch -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_prefetch)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation did not complete"
  exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1
